/* logic/carPkg.sv */
package carPkg;

	localparam int PosWidth = 3; // half-step count 0..6
	localparam int CountWidth = 4;

	localparam logic [CountWidth-1:0] DwellCycles = 4'd5; // door may close from here on
	localparam logic [CountWidth-1:0] CloseEarlyCycles = 4'd3; // earliest Dclose shortcut

	typedef enum logic [1:0] {
		IDLE = 2'b00,
		UP = 2'b01,
		DOWN = 2'b10
	} direction_e;

	typedef enum logic {
		CLOSED = 1'b0,
		OPEN = 1'b1
	} doorState_e;

	typedef struct packed {
		logic [PosWidth-2:0] landing; // landing at or just below the car
		logic between; // set while between two landings
	} posSplit_s;

	// one position word, read either as a count or as landing plus between bit
	typedef union packed {
		logic [PosWidth-1:0] raw;
		posSplit_s split;
	} carPos_u;

endpackage

/* logic/panelPkg.sv */
package panelPkg;

	// buttons that belong to one landing
	typedef struct packed {
		logic hallUp;
		logic hallDown;
		logic car; // button inside the car for this landing
	} landingButtons_s;

	// latched calls seen from the car position
	typedef struct packed {
		logic here; // call at the landing the car stands at
		logic above;
		logic below;
	} requestSummary_s;

endpackage

/* logic/buttonPanel.sv */
`timescale 1ns/100ps

module buttonPanel #(
	parameter int NumLandings = 4
) (
	input logic F1,
	input logic F2,
	input logic F3,
	input logic F4,
	input logic F1up,
	input logic F2down,
	input logic F2up,
	input logic F3down,
	input logic F3up,
	input logic F4down,
	output panelPkg::landingButtons_s buttons [NumLandings]
);

	logic [3:0] carBits;
	logic [3:0] upBits;
	logic [3:0] downBits;

	assign carBits = {F4, F3, F2, F1};
	assign upBits = {1'b0, F3up, F2up, F1up}; // no up call at the top landing
	assign downBits = {F4down, F3down, F2down, 1'b0}; // no down call at the bottom

	// one regular struct per landing for the station array
	for (genvar i = 0; i < NumLandings; i++) begin : g_landing
		assign buttons[i] = '{
			hallUp: upBits[i],
			hallDown: downBits[i],
			car: carBits[i]
		};
	end

endmodule

/* logic/landingStation.sv */
`timescale 1ns/100ps

module landingStation #(
	parameter int LandingIndex = 0
) (
	input logic clk,
	input logic reset,
	input panelPkg::landingButtons_s buttons,
	input carPkg::carPos_u carPos,
	input logic serve,
	input logic aboveIn,
	input logic belowIn,
	output logic here,
	output logic aboveOut,
	output logic belowOut
);

	panelPkg::landingButtons_s calls;
	logic pending;
	logic atLanding;
	logic isAbove;
	logic isBelow;

	always_ff @(posedge clk) begin
		if (reset || serve) begin
			calls <= '0; // serving the landing drops every call bit
		end else begin
			calls <= calls | buttons;
		end
	end

	assign pending = |calls;

	// a car between landings counts as above the lower one
	assign atLanding = (LandingIndex == int'(carPos.split.landing)) && !carPos.split.between;
	assign isAbove = LandingIndex > int'(carPos.split.landing);
	assign isBelow = !isAbove && !atLanding;

	assign here = atLanding && pending;
	assign aboveOut = aboveIn || (isAbove && pending);
	assign belowOut = belowIn || (isBelow && pending);

endmodule

/* logic/travelScheduler.sv */
`timescale 1ns/100ps

module travelScheduler #(
	parameter int NumLandings = 4
) (
	input logic clk,
	input logic reset,
	input panelPkg::requestSummary_s requests,
	input logic Emergency,
	input logic doorOpen,
	output carPkg::carPos_u carPos,
	output carPkg::direction_e state,
	output logic [NumLandings-1:0] serve,
	output logic arrive,
	output logic holdOpen
);

	carPkg::direction_e heading; // last travel direction, kept across stops
	carPkg::direction_e pick;
	logic atLanding;

	assign atLanding = !carPos.split.between;

	// emergency stops at the next landing reached
	assign holdOpen = Emergency && atLanding;
	assign arrive = atLanding && !doorOpen && (requests.here || Emergency);

	// collective rule, the current heading wins while calls lie ahead
	always_comb begin
		if (heading == carPkg::DOWN) begin
			if (requests.below)
				pick = carPkg::DOWN;
			else if (requests.above)
				pick = carPkg::UP;
			else
				pick = carPkg::IDLE;
		end else begin
			if (requests.above)
				pick = carPkg::UP;
			else if (requests.below)
				pick = carPkg::DOWN;
			else
				pick = carPkg::IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			carPos.raw <= '0;
			state <= carPkg::IDLE;
			heading <= carPkg::UP;
		end else if (!atLanding) begin
			// always finish the half-step in progress
			if (state == carPkg::DOWN)
				carPos.raw <= carPos.raw - 1'b1;
			else
				carPos.raw <= carPos.raw + 1'b1;
		end else if (arrive || doorOpen) begin
			state <= carPkg::IDLE; // stopped with the door opening or open
		end else begin
			state <= pick;
			if (pick != carPkg::IDLE)
				heading <= pick;
			if (pick == carPkg::UP)
				carPos.raw <= carPos.raw + 1'b1;
			else if (pick == carPkg::DOWN)
				carPos.raw <= carPos.raw - 1'b1;
		end
	end

	// clear the served landing, or all of them on emergency
	always_comb begin
		for (int i = 0; i < NumLandings; i++) begin
			serve[i] = holdOpen ||
				(doorOpen && atLanding && (int'(carPos.split.landing) == i));
		end
	end

endmodule

/* logic/doorTimer.sv */
`timescale 1ns/100ps

module doorTimer (
	input logic clk,
	input logic reset,
	input logic arrive,
	input logic holdOpen,
	input logic Dsensor,
	input logic Dopen,
	input logic Dclose,
	output logic doorOpen
);

	carPkg::doorState_e door;
	logic [carPkg::CountWidth-1:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			door <= carPkg::CLOSED;
			count <= '0;
		end else if (holdOpen) begin
			door <= carPkg::OPEN; // emergency, dwell does not start yet
			count <= '0;
		end else if (door == carPkg::CLOSED) begin
			if (arrive || Dopen) begin
				door <= carPkg::OPEN;
				count <= '0;
			end
		end else if (count >= carPkg::DwellCycles) begin
			// doorway sensor keeps the door open
			if (!Dsensor)
				door <= carPkg::CLOSED;
		end else if (Dclose && count >= carPkg::CloseEarlyCycles) begin
			count <= carPkg::DwellCycles; // skip the rest of the dwell
		end else begin
			count <= count + 1'b1;
		end
	end

	assign doorOpen = (door == carPkg::OPEN);

endmodule

/* logic/elevatorController.sv */
`timescale 1ns/100ps

module elevatorController #(
	parameter int NumLandings = 4
) (
	input logic clk,
	input logic reset,
	input logic Dsensor,
	input logic Emergency,
	input logic Dopen,
	input logic Dclose,
	input logic F1,
	input logic F2,
	input logic F3,
	input logic F4,
	input logic F1up,
	input logic F2down,
	input logic F2up,
	input logic F3down,
	input logic F3up,
	input logic F4down,
	output carPkg::direction_e state,
	output logic [carPkg::PosWidth-1:0] floor,
	output logic doorOpen
);

	panelPkg::landingButtons_s buttons [NumLandings];
	panelPkg::requestSummary_s requests;
	carPkg::carPos_u carPos;
	logic [NumLandings-1:0] serve;
	logic [NumLandings-1:0] hereBits;
	logic [NumLandings:0] aboveChain; // ripples from the top landing down
	logic [NumLandings:0] belowChain; // ripples from landing 0 up
	logic arrive;
	logic holdOpen;
	logic dopenIdle;

	buttonPanel #(
		.NumLandings(NumLandings)
	) i_buttonPanel (
		.F1(F1),
		.F2(F2),
		.F3(F3),
		.F4(F4),
		.F1up(F1up),
		.F2down(F2down),
		.F2up(F2up),
		.F3down(F3down),
		.F3up(F3up),
		.F4down(F4down),
		.buttons(buttons)
	);

	assign aboveChain[NumLandings] = 1'b0;
	assign belowChain[0] = 1'b0;

	for (genvar i = 0; i < NumLandings; i++) begin : g_station
		landingStation #(
			.LandingIndex(i)
		) i_landingStation (
			.clk(clk),
			.reset(reset),
			.buttons(buttons[i]),
			.carPos(carPos),
			.serve(serve[i]),
			.aboveIn(aboveChain[i+1]),
			.belowIn(belowChain[i]),
			.here(hereBits[i]),
			.aboveOut(aboveChain[i]),
			.belowOut(belowChain[i+1])
		);
	end

	assign requests = '{
		here: |hereBits,
		above: aboveChain[0],
		below: belowChain[NumLandings]
	};

	travelScheduler #(
		.NumLandings(NumLandings)
	) i_travelScheduler (
		.clk(clk),
		.reset(reset),
		.requests(requests),
		.Emergency(Emergency),
		.doorOpen(doorOpen),
		.carPos(carPos),
		.state(state),
		.serve(serve),
		.arrive(arrive),
		.holdOpen(holdOpen)
	);

	// Dopen only counts while the car rests with nothing to travel to
	assign dopenIdle = Dopen && (state == carPkg::IDLE) && !requests.above && !requests.below;

	doorTimer i_doorTimer (
		.clk(clk),
		.reset(reset),
		.arrive(arrive),
		.holdOpen(holdOpen),
		.Dsensor(Dsensor),
		.Dopen(dopenIdle),
		.Dclose(Dclose),
		.doorOpen(doorOpen)
	);

	assign floor = carPos.raw;

endmodule

/* tb/elevatorController_checker.sv */
`timescale 1ns/100ps

module elevatorController_checker (
	input logic clk,
	input logic reset,
	input carPkg::carPos_u carPos,
	input carPkg::direction_e state,
	input logic doorOpen
);

	int failures = 0; // failed assertions so far

	// one half-step per clock at most
	assert property (@(posedge clk) disable iff (reset)
		(int'(carPos.raw) - int'($past(carPos.raw))) inside {-1, 0, 1})
		else begin
			failures++;
			$error("car position jumped by more than one half-step");
		end

	assert property (@(posedge clk) disable iff (reset) doorOpen |=> $stable(carPos.raw))
		else begin
			failures++;
			$error("car position changed while the door was open");
		end

	assert property (@(posedge clk) disable iff (reset) !(doorOpen && carPos.split.between))
		else begin
			failures++;
			$error("door open between two landings");
		end

	assert property (@(posedge clk) disable iff (reset) doorOpen |-> state == carPkg::IDLE)
		else begin
			failures++;
			$error("car not idle while the door was open");
		end

endmodule

bind elevatorController elevatorController_checker i_checker (
	.clk(clk),
	.reset(reset),
	.carPos(carPos),
	.state(state),
	.doorOpen(doorOpen)
);

/* tb/elevatorController_tb.sv */
`timescale 1ns/100ps

module elevatorController_tb;

	// fields in the bit order of the data file input column with MSB first
	typedef struct packed {
		logic Dsensor;
		logic Emergency;
		logic Dopen;
		logic Dclose;
		logic F1;
		logic F2;
		logic F3;
		logic F4;
		logic F1up;
		logic F2down;
		logic F2up;
		logic F3down;
		logic F3up;
		logic F4down;
	} panelInputs_s;

	logic clk;
	logic reset;
	panelInputs_s pins;
	carPkg::direction_e state;
	logic [carPkg::PosWidth-1:0] floor;
	logic doorOpen;
	string testName; // name of the data file line being run

	elevatorController #(
		.NumLandings(4)
	) i_elevatorController (
		.clk(clk),
		.reset(reset),
		.Dsensor(pins.Dsensor),
		.Emergency(pins.Emergency),
		.Dopen(pins.Dopen),
		.Dclose(pins.Dclose),
		.F1(pins.F1),
		.F2(pins.F2),
		.F3(pins.F3),
		.F4(pins.F4),
		.F1up(pins.F1up),
		.F2down(pins.F2down),
		.F2up(pins.F2up),
		.F3down(pins.F3down),
		.F3up(pins.F3up),
		.F4down(pins.F4down),
		.state(state),
		.floor(floor),
		.doorOpen(doorOpen)
	);

	always #50 clk = ~clk;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkPos(input carPkg::carPos_u expected, input carPkg::carPos_u actual);
		if (actual.raw !== expected.raw)
			abortRun($sformatf("MISMATCH %s floor expected %0d actual %0d",
				testName, expected.raw, actual.raw));
	endtask

	task automatic checkState(input carPkg::direction_e expected,
		input carPkg::direction_e actual);
		if (actual !== expected)
			abortRun($sformatf("MISMATCH %s state expected %0d actual %0d",
				testName, expected, actual));
	endtask

	task automatic checkDoor(input logic expected, input logic actual);
		if (actual !== expected)
			abortRun($sformatf("MISMATCH %s doorOpen expected %0b actual %0b",
				testName, expected, actual));
	endtask

	// limit is the number of cycles allowed for the door to reach level
	task automatic waitDoor(input logic level, input int limit);
		int count;
		count = 0;
		while (doorOpen !== level) begin
			if (count >= limit)
				abortRun($sformatf("timeout in %s, door never reached %0b", testName, level));
			@(negedge clk);
			count++;
		end
	endtask

	always @(i_elevatorController.i_checker.failures) begin
		if (i_elevatorController.i_checker.failures != 0)
			abortRun($sformatf("assertion in the bound checker failed during %s", testName));
	end

	initial begin
		int fd;
		int fields;
		int hold;
		int arg;
		int expFloor;
		int expState;
		int expDoor;
		string line;
		string waitKind;
		logic [13:0] vecBits;
		carPkg::carPos_u expPos;
		carPkg::carPos_u actualPos;

		clk = 1'b0;
		reset = 1'b1;
		pins = '0;
		testName = "reset";
		repeat (3) @(negedge clk);
		reset = 1'b0;

		fd = $fopen("tb/elevatorController_input.txt", "r");
		if (fd == 0)
			abortRun("could not open the stimulus file tb/elevatorController_input.txt");
		while ($fgets(line, fd) > 0) begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			fields = $sscanf(line, "%s %h %d %s %d %d %d %d", testName, vecBits, hold,
				waitKind, arg, expFloor, expState, expDoor);
			if (fields != 8)
				abortRun({"stimulus file line could not be parsed: ", line});
			pins = panelInputs_s'(vecBits);
			repeat (hold) @(negedge clk);
			pins = '0; // buttons released before the wait
			if (waitKind == "open")
				waitDoor(1'b1, arg);
			else if (waitKind == "close")
				waitDoor(1'b0, arg);
			else if (waitKind == "cycles")
				repeat (arg) @(negedge clk);
			else
				abortRun({"unknown wait kind in stimulus file: ", waitKind});
			expPos.raw = expFloor[carPkg::PosWidth-1:0];
			actualPos.raw = floor;
			checkPos(expPos, actualPos);
			checkState(carPkg::direction_e'(expState), state);
			checkDoor(expDoor[0], doorOpen);
		end
		$fclose(fd);
		$display("** PASS **");
		$finish;
	end

endmodule

/* tb/elevatorController_input.txt */
# name inputs(hex Dsensor Emergency Dopen Dclose F1 F2 F3 F4 F1up F2down F2up F3down F3up F4down)
# hold wait arg floor state(0 idle 1 up 2 down) door; arg is a timeout for open/close
reset_state 0000 0 cycles 0 0 0 0
call_f3 0080 1 cycles 1 1 1 0
arrive_f3 0000 0 open 20 4 0 1
dwell_open 0000 0 cycles 5 4 0 1
dwell_close 0000 0 cycles 1 4 0 0
reopen_f3 0080 1 open 5 4 0 1
close_early_held 0400 4 cycles 0 4 0 1
close_early_shut 0000 0 cycles 1 4 0 0
reopen_again 0080 1 open 5 4 0 1
sensor_hold 2000 10 cycles 0 4 0 1
sensor_release 0000 0 close 3 4 0 0
return_f1 0200 1 open 20 0 0 1
return_close 0000 0 close 20 0 0 0
depart_f4 0040 1 cycles 1 1 1 0
latch_f2up 0008 1 open 5 2 0 1
leave_f2 0000 0 close 20 2 0 0
collect_f4 0000 0 open 20 6 0 1
idle_f4 0000 0 close 20 6 0 0
idle_f4_stay 0000 0 cycles 3 6 0 0
reverse_press 0204 1 cycles 1 5 2 0
stop_f3down 0000 0 open 20 4 0 1
leave_f3 0000 0 close 20 4 0 0
stop_f1 0000 0 open 20 0 0 1
rest_f1 0000 0 close 20 0 0 0
emergency_depart 0040 1 cycles 1 1 1 0
emergency_stop 1000 2 cycles 0 2 0 1
emergency_hold 1000 12 cycles 0 2 0 1
emergency_release 0000 0 close 20 2 0 0
calls_cleared 0000 0 cycles 5 2 0 0

/* elevatorController.f */
logic/carPkg.sv
logic/panelPkg.sv
logic/buttonPanel.sv
logic/landingStation.sv
logic/travelScheduler.sv
logic/doorTimer.sv
logic/elevatorController.sv
tb/elevatorController_checker.sv
tb/elevatorController_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --timing --assert
LINT_FLAGS = --lint-only -Wall
SIM_FLAGS = --binary -Wno-fatal
TOP = elevatorController_tb
FILELIST = elevatorController.f
BUILD_DIR = obj_dir
PASS_MSG = ** PASS **

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
